//--- rtl/pdp8_pkg.sv
// Word types, sequencer states and opcode constants shared by the PDP-8 core; import in each block.
package pdp8_pkg;

    // ==============================
    // words and fields
    // ==============================
    typedef logic [0:11] word_t;     // bit 0 is the most significant bit, as on the PDP-8.
    typedef logic [0:11] addr_t;
    typedef logic [0:2]  opcode_t;

    localparam int mem_words = 4096;

    // ==============================
    // major states
    // ==============================
    typedef enum logic [2:0] {
        st_halt,
        st_fetch,
        st_defer,
        st_exec,
        st_write,
        st_panel
    } major_state_t;

    // ==============================
    // major opcodes
    // ==============================
    localparam opcode_t op_and = 3'd0;
    localparam opcode_t op_tad = 3'd1;
    localparam opcode_t op_isz = 3'd2;
    localparam opcode_t op_dca = 3'd3;
    localparam opcode_t op_jms = 3'd4;
    localparam opcode_t op_jmp = 3'd5;
    localparam opcode_t op_iot = 3'd6;
    localparam opcode_t op_opr = 3'd7;

endpackage

//--- rtl/front_panel.sv
// Front panel key conditioning; feeds synchronized switch levels and command pulses to the core.
`timescale 1ns/10ps

module front_panel (
    input  logic clk,
    input  logic arst_n,
    input  logic addr_loadn,
    input  logic depn,
    input  logic examn,
    input  logic contn,
    input  logic clearn,
    input  logic haltn,
    input  logic single_stepn,
    output logic load_addr_cmd,
    output logic dep_cmd,
    output logic exam_cmd,
    output logic cont_cmd,
    output logic clear_cmd,
    output logic halt_sw,
    output logic step_sw
);

    logic [6:0] sync_q1;    // keys inverted, so a pressed key reads as one.
    logic [6:0] sync_q2;
    logic [4:0] prev_q;     // previous level of the five command keys.
    logic [4:0] pulse_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
            pulse_q <= '0;
        end
        else
        begin
            sync_q1 <= ~{addr_loadn, depn, examn, contn, clearn, haltn, single_stepn};
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2[6:2];
            pulse_q <= sync_q2[6:2] & ~prev_q;    // one cycle per press.
        end
    end

    assign load_addr_cmd = pulse_q[4];
    assign dep_cmd       = pulse_q[3];
    assign exam_cmd      = pulse_q[2];
    assign cont_cmd      = pulse_q[1];
    assign clear_cmd     = pulse_q[0];
    assign halt_sw       = sync_q2[1];
    assign step_sw       = sync_q2[0];

endmodule

//--- rtl/state_machine.sv
// Major-state sequencer of the core; steps fetch, defer, execute, write and panel memory cycles.
`timescale 1ns/10ps

module state_machine (
    input  logic                   clk,
    input  logic                   arst_n,
    input  pdp8_pkg::word_t        instruction,
    input  logic                   load_addr_cmd,
    input  logic                   dep_cmd,
    input  logic                   exam_cmd,
    input  logic                   cont_cmd,
    input  logic                   halt_sw,
    input  logic                   step_sw,
    input  logic                   halt_req,
    output pdp8_pkg::major_state_t state,
    output logic                   run,
    output logic                   first_cycle
);

    import pdp8_pkg::*;

    word_t        ir;              // instruction register, loaded at the end of fetch.
    opcode_t      op;
    major_state_t next_state;
    major_state_t done_state;      // where a completed instruction goes.
    major_state_t operand_state;   // first state after the address is known.

    always_comb
    begin
        op = (state == st_fetch) ? instruction[0:2] : ir[0:2];
        done_state = (halt_req || halt_sw || step_sw) ? st_halt : st_fetch;
        case (op)
            op_and, op_tad, op_isz: operand_state = st_exec;
            op_dca, op_jms:         operand_state = st_write;
            default:                operand_state = done_state;
        endcase
        next_state = state;
        case (state)
            st_halt:
                if (!load_addr_cmd && (dep_cmd || exam_cmd))
                    next_state = st_panel;
                else if (!load_addr_cmd && cont_cmd)
                    next_state = st_fetch;
            st_panel:
                if (!first_cycle)
                    next_state = st_halt;
            st_fetch:
                if (!first_cycle)
                begin
                    if (op == op_iot || op == op_opr)
                        next_state = done_state;
                    else if (instruction[3])
                        next_state = st_defer;     // indirect bit.
                    else
                        next_state = operand_state;
                end
            st_defer:
                if (!first_cycle)
                    next_state = operand_state;
            st_exec:
                if (!first_cycle)
                    next_state = (op == op_isz) ? st_write : done_state;
            st_write:
                next_state = done_state;
            default:
                next_state = st_halt;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= st_halt;
            first_cycle <= 1'b0;
            run         <= 1'b0;
            ir          <= '0;
        end
        else
        begin
            state       <= next_state;
            first_cycle <= (next_state != state) || (!first_cycle && next_state != st_halt);
            run         <= next_state inside {st_fetch, st_defer, st_exec, st_write};
            if (state == st_fetch && !first_cycle)
                ir <= instruction;
        end
    end

    a_no_opr_defer: assert property (@(posedge clk) disable iff (!arst_n)
        state == st_defer |-> ir[0:2] != op_opr);

    a_halt_not_running: assert property (@(posedge clk) disable iff (!arst_n)
        state == st_halt |-> !run);

endmodule

//--- rtl/ma.sv
// Memory and address unit; holds core memory, PC, MA and MB and forms effective addresses.
`timescale 1ns/10ps

module ma (
    input  logic                   clk,
    input  logic                   arst_n,
    input  pdp8_pkg::major_state_t state,
    input  logic                   first_cycle,
    input  pdp8_pkg::word_t        instruction,
    input  pdp8_pkg::word_t        sr,
    input  logic                   load_addr_cmd,
    input  logic                   dep_cmd,
    input  pdp8_pkg::word_t        ac,
    input  logic                   link,
    input  logic                   skip,
    input  logic                   isz_zero,
    input  pdp8_pkg::word_t        isz_data,
    output pdp8_pkg::word_t        mb,
    output pdp8_pkg::addr_t        pc,
    output pdp8_pkg::addr_t        ma_reg
);

    import pdp8_pkg::*;

    word_t   mem [mem_words];
    word_t   wr_data;
    addr_t   wr_addr;
    addr_t   eff_addr;
    opcode_t op_q;
    logic    panel_wr;    // the pending panel cycle is a deposit.
    logic    mem_we;

    // page bits come from the fetch address held in ma_reg.
    assign eff_addr = {instruction[4] ? ma_reg[0:4] : 5'b0, instruction[5:11]};
    assign mem_we   = (state == st_write) || (state == st_panel && first_cycle && panel_wr);
    assign wr_addr  = (state == st_panel) ? pc : ma_reg;

    always_comb
    begin
        case (op_q)
            op_dca:  wr_data = ac;
            op_jms:  wr_data = pc;        // return address.
            default: wr_data = isz_data;
        endcase
        if (state == st_panel)
            wr_data = sr;
    end

    always_ff @(posedge clk)
    begin
        if (mem_we)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc       <= '0;
            ma_reg   <= '0;
            mb       <= '0;
            op_q     <= op_and;
            panel_wr <= 1'b0;
        end
        else
        begin
            case (state)
                st_halt:
                begin
                    if (load_addr_cmd)
                        pc <= sr;
                    if (dep_cmd)
                        panel_wr <= 1'b1;
                    else if (!load_addr_cmd)
                        panel_wr <= 1'b0;
                end
                st_panel:
                    if (first_cycle)
                        mb <= panel_wr ? sr : mem[pc];
                    else
                        pc <= pc + 12'd1;
                st_fetch:
                    if (first_cycle)
                    begin
                        mb     <= mem[pc];
                        ma_reg <= pc;
                        pc     <= pc + 12'd1;
                    end
                    else
                    begin
                        op_q   <= instruction[0:2];
                        ma_reg <= eff_addr;
                        if (instruction[0:2] == op_jmp && !instruction[3])
                            pc <= eff_addr;
                        else if (skip)
                            pc <= pc + 12'd1;
                    end
                st_defer:
                    if (first_cycle)
                        mb <= mem[ma_reg];
                    else
                    begin
                        ma_reg <= mb;             // pointer replaces the address.
                        if (op_q == op_jmp)
                            pc <= mb;
                    end
                st_exec:
                    if (first_cycle)
                        mb <= mem[ma_reg];
                st_write:
                begin
                    mb <= wr_data;
                    if (op_q == op_jms)
                        pc <= ma_reg + 12'd1;
                    else if (isz_zero)
                        pc <= pc + 12'd1;
                end
                default: ;
            endcase
        end
    end

    a_no_write_in_fetch: assert property (@(posedge clk) disable iff (!arst_n)
        mem_we |-> !(state inside {st_fetch, st_defer}));

endmodule

//--- rtl/ac.sv
// Accumulator unit; executes AND, TAD, DCA, the ISZ increment and group-1 and group-2 operate.
`timescale 1ns/10ps

module ac (
    input  logic                   clk,
    input  logic                   arst_n,
    input  pdp8_pkg::major_state_t state,
    input  logic                   first_cycle,
    input  pdp8_pkg::word_t        instruction,
    input  pdp8_pkg::word_t        mb,
    input  pdp8_pkg::word_t        sr,
    input  logic                   clear_cmd,
    output pdp8_pkg::word_t        ac,
    output logic                   link,
    output logic                   isz_zero,
    output pdp8_pkg::word_t        isz_data
);

    import pdp8_pkg::*;

    opcode_t     op_q;
    logic [0:12] tad_sum;     // bit 0 is the carry.
    logic [0:12] grp1;
    word_t       grp2;

    // group-1 microinstructions on {link, ac}, in PDP-8 order.
    function automatic logic [0:12] operate1(input word_t ir, input logic [0:12] lac);
        logic [0:12] v;
        v = lac;
        if (ir[4])
            v[1:12] = '0;
        if (ir[5])
            v[0] = 1'b0;
        if (ir[6])
            v[1:12] = ~v[1:12];
        if (ir[7])
            v[0] = ~v[0];
        if (ir[11])
            v = v + 13'd1;        // a carry out of AC complements the link.
        if (ir[8])
            v = {v[12], v[0:11]};
        if (ir[8] && ir[10])
            v = {v[12], v[0:11]};
        if (ir[9])
            v = {v[1:12], v[0]};
        if (ir[9] && ir[10])
            v = {v[1:12], v[0]};
        return v;
    endfunction

    assign tad_sum  = {1'b0, ac} + {1'b0, mb};
    assign grp1     = operate1(instruction, {link, ac});
    assign grp2     = (instruction[4] ? 12'd0 : ac) | (instruction[9] ? sr : 12'd0);
    assign isz_data = mb + 12'd1;
    assign isz_zero = (op_q == op_isz) && (isz_data == 12'd0);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ac   <= '0;
            link <= 1'b0;
            op_q <= op_and;
        end
        else
        begin
            case (state)
                st_halt:
                    if (clear_cmd)
                    begin
                        ac   <= '0;
                        link <= 1'b0;
                    end
                st_fetch:
                    if (!first_cycle)
                    begin
                        op_q <= instruction[0:2];
                        if (instruction[0:2] == op_opr && !instruction[3])
                            {link, ac} <= grp1;
                        else if (instruction[0:2] == op_opr && !instruction[11])
                            ac <= grp2;           // CLA and OSR of group 2.
                    end
                st_exec:
                    if (!first_cycle && op_q == op_and)
                        ac <= ac & mb;
                    else if (!first_cycle && op_q == op_tad)
                    begin
                        ac   <= tad_sum[1:12];
                        link <= link ^ tad_sum[0];
                    end
                st_write:
                    if (op_q == op_dca)
                        ac <= '0;
                default: ;
            endcase
        end
    end

endmodule

//--- rtl/oper2.sv
// Group-2 operate decode; gives the skip and halt requests at the end of each fetch.
`timescale 1ns/10ps

module oper2 (
    input  logic                   clk,
    input  pdp8_pkg::major_state_t state,
    input  pdp8_pkg::word_t        instruction,
    input  pdp8_pkg::word_t        ac,
    input  logic                   link,
    output logic                   skip,
    output logic                   halt_req
);

    import pdp8_pkg::*;

    logic phase;      // high in the second cycle of fetch.
    logic group2;
    logic cond;

    always_ff @(posedge clk)
    begin
        phase <= (state == st_fetch) && !phase;
    end

    assign group2 = (state == st_fetch) && phase && (instruction[0:2] == op_opr)
                    && instruction[3] && !instruction[11];

    // SMA, SZA and SNL look at AC before any CLA of the same word.
    assign cond = (instruction[5] && ac[0]) || (instruction[6] && ac == 12'd0)
                  || (instruction[7] && link);

    assign skip     = group2 && (cond ^ instruction[8]);   // bit 8 gives SPA, SNA, SZL.
    assign halt_req = group2 && instruction[10];

endmodule

//--- rtl/pdp8_core.sv
// Top level of the reduced PDP-8; connects front panel, sequencer, memory, accumulator and skips.
`timescale 1ns/10ps

module pdp8_core (
    input  logic            clk,
    input  logic            arst_n,
    input  pdp8_pkg::word_t sr,
    input  logic            addr_loadn,
    input  logic            depn,
    input  logic            examn,
    input  logic            contn,
    input  logic            clearn,
    input  logic            haltn,
    input  logic            single_stepn,
    output pdp8_pkg::word_t ac,
    output pdp8_pkg::word_t mb,
    output pdp8_pkg::addr_t pc,
    output logic            link,
    output logic            run
);

    import pdp8_pkg::*;

    logic         load_addr_cmd;
    logic         dep_cmd;
    logic         exam_cmd;
    logic         cont_cmd;
    logic         clear_cmd;
    logic         halt_sw;
    logic         step_sw;
    major_state_t state;
    logic         first_cycle;
    logic         skip;
    logic         halt_req;
    logic         isz_zero;
    word_t        isz_data;

    front_panel front_panel_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .addr_loadn    (addr_loadn),
        .depn          (depn),
        .examn         (examn),
        .contn         (contn),
        .clearn        (clearn),
        .haltn         (haltn),
        .single_stepn  (single_stepn),
        .load_addr_cmd (load_addr_cmd),
        .dep_cmd       (dep_cmd),
        .exam_cmd      (exam_cmd),
        .cont_cmd      (cont_cmd),
        .clear_cmd     (clear_cmd),
        .halt_sw       (halt_sw),
        .step_sw       (step_sw)
    );

    // mb carries the instruction word during fetch.
    state_machine state_machine_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .instruction   (mb),
        .load_addr_cmd (load_addr_cmd),
        .dep_cmd       (dep_cmd),
        .exam_cmd      (exam_cmd),
        .cont_cmd      (cont_cmd),
        .halt_sw       (halt_sw),
        .step_sw       (step_sw),
        .halt_req      (halt_req),
        .state         (state),
        .run           (run),
        .first_cycle   (first_cycle)
    );

    ma ma_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .state         (state),
        .first_cycle   (first_cycle),
        .instruction   (mb),
        .sr            (sr),
        .load_addr_cmd (load_addr_cmd),
        .dep_cmd       (dep_cmd),
        .ac            (ac),
        .link          (link),
        .skip          (skip),
        .isz_zero      (isz_zero),
        .isz_data      (isz_data),
        .mb            (mb),
        .pc            (pc),
        .ma_reg        ()
    );

    ac ac_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .state         (state),
        .first_cycle   (first_cycle),
        .instruction   (mb),
        .mb            (mb),
        .sr            (sr),
        .clear_cmd     (clear_cmd),
        .ac            (ac),
        .link          (link),
        .isz_zero      (isz_zero),
        .isz_data      (isz_data)
    );

    oper2 oper2_i (
        .clk           (clk),
        .state         (state),
        .instruction   (mb),
        .ac            (ac),
        .link          (link),
        .skip          (skip),
        .halt_req      (halt_req)
    );

endmodule

//--- testbench/tb_clock.sv
// Clock and reset source for the PDP-8 core testbench; instantiated once by the testbench top.
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // 100 ns period.
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- testbench/pdp8_core_tb.sv
// Testbench top for the PDP-8 core; loads programs through the front panel, runs them and checks.
`timescale 1ns/10ps

module pdp8_core_tb;

    localparam int n_progs   = 6;
    localparam int n_fields  = 18;
    localparam int run_limit = 2000;
    localparam logic [11:0] run_sr = 12'o4321;

    // fields of a table row.
    localparam int f_start = 0;
    localparam int f_count = 1;
    localparam int f_code  = 2;
    localparam int f_daddr = 10;
    localparam int f_data  = 11;
    localparam int f_rand  = 12;
    localparam int f_ac    = 13;
    localparam int f_link  = 14;
    localparam int f_pc    = 15;
    localparam int f_chk   = 16;
    localparam int f_mem   = 17;

    localparam int key_load  = 0;
    localparam int key_dep   = 1;
    localparam int key_exam  = 2;
    localparam int key_cont  = 3;
    localparam int key_clear = 4;

    logic        clk;
    logic        arst_n;
    logic [11:0] sr;
    logic        addr_loadn;
    logic        depn;
    logic        examn;
    logic        contn;
    logic        clearn;
    logic        haltn;
    logic        single_stepn;
    logic [11:0] ac;
    logic [11:0] mb;
    logic [11:0] pc;
    logic        link;
    logic        run;

    logic [11:0] prog_table [n_progs][n_fields];
    int unsigned lcg_state;

    tb_clock tb_clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    pdp8_core pdp8_core_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .sr           (sr),
        .addr_loadn   (addr_loadn),
        .depn         (depn),
        .examn        (examn),
        .contn        (contn),
        .clearn       (clearn),
        .haltn        (haltn),
        .single_stepn (single_stepn),
        .ac           (ac),
        .mb           (mb),
        .pc           (pc),
        .link         (link),
        .run          (run)
    );

    // ==============================
    // program table
    // ==============================
    // row: start, count, code 0 to 7, data address, data, random, ac, link, pc, check address, word.
    task automatic fill_table();
        prog_table[0] = '{12'o0200, 12'd8,
                          12'o7300, 12'o1206, 12'o1050, 12'o0207,
                          12'o3051, 12'o7402, 12'o6000, 12'o7707,
                          12'o0050, 12'o3234, 12'd0, 12'o0000, 12'd1, 12'o0206, 12'o0051, 12'o1204};
        prog_table[1] = '{12'o0400, 12'd4,
                          12'o7300, 12'o1060, 12'o3061, 12'o7402,
                          12'o0000, 12'o0000, 12'o0000, 12'o0000,
                          12'o0060, 12'o0000, 12'd1, 12'o0000, 12'd0, 12'o0404, 12'o0061, 12'o0000};
        // JMS to 0605 twice, ISZ on a counter of minus two ends the loop.
        prog_table[2] = '{12'o0600, 12'd8,
                          12'o7300, 12'o4205, 12'o2070, 12'o5201,
                          12'o7402, 12'o0000, 12'o7001, 12'o5605,
                          12'o0070, 12'o7776, 12'd0, 12'o0002, 12'd0, 12'o0605, 12'o0605, 12'o0602};
        prog_table[3] = '{12'o1000, 12'd6,
                          12'o7341, 12'o1100, 12'o7004, 12'o7012,
                          12'o7020, 12'o7402, 12'o0000, 12'o0000,
                          12'o0100, 12'o2525, 12'd0, 12'o5252, 12'd0, 12'o1006, 12'o0100, 12'o2525};
        prog_table[4] = '{12'o1200, 12'd8,
                          12'o7300, 12'o7440, 12'o7402, 12'o7604,
                          12'o7510, 12'o7410, 12'o7402, 12'o7402,
                          12'o0053, 12'o1111, 12'd0, 12'o4321, 12'd0, 12'o1210, 12'o0053, 12'o1111};
        prog_table[5] = '{12'o1400, 12'd8,
                          12'o7320, 12'o7420, 12'o7402, 12'o1052,
                          12'o7500, 12'o7402, 12'o7430, 12'o7402,
                          12'o0052, 12'o7000, 12'd0, 12'o7000, 12'd1, 12'o1410, 12'o0052, 12'o7000};
    endtask

    function automatic logic [11:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[27:16];
    endfunction

    // ==============================
    // reporting
    // ==============================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [11:0] actual,
                               input logic [11:0] expected);
        if (actual !== expected)
            abort_run($sformatf("FAIL at %0t ns: %s is %04o, expected %04o",
                                $time, name, actual, expected));
    endtask

    // ==============================
    // front panel
    // ==============================
    task automatic drive_key(input int key_id, input logic level);
        case (key_id)
            key_load:  addr_loadn <= level;
            key_dep:   depn       <= level;
            key_exam:  examn      <= level;
            key_cont:  contn      <= level;
            key_clear: clearn     <= level;
            default: ;
        endcase
    endtask

    // keys are active low, held and released for 4 cycles each.
    task automatic press_key(input int key_id);
        @(posedge clk);
        drive_key(key_id, 1'b0);
        repeat (4) @(posedge clk);
        drive_key(key_id, 1'b1);
        repeat (4) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic load_address(input logic [11:0] addr);
        @(posedge clk);
        sr <= addr;
        press_key(key_load);
    endtask

    task automatic deposit_word(input logic [11:0] word);
        @(posedge clk);
        sr <= word;
        press_key(key_dep);
    endtask

    task automatic examine_word();
        press_key(key_exam);
    endtask

    task automatic wait_reset();
        int count;
        count = 0;
        while (arst_n !== 1'b1 && count < 20)
        begin
            @(negedge clk);
            count++;
        end
        if (arst_n !== 1'b1)
            abort_run("reset was not released within 20 cycles");
    endtask

    task automatic wait_run(input logic level);
        int count;
        count = 0;
        @(negedge clk);
        while (run !== level && count < run_limit)
        begin
            @(negedge clk);
            count++;
        end
        if (run !== level && level)
            abort_run("run did not go high after continue");
        else if (run !== level)
            abort_run("run did not fall, the program did not halt");
    endtask

    // holds continue until the processor runs, then waits for the halt.
    task automatic continue_run();
        @(posedge clk);
        contn <= 1'b0;
        wait_run(1'b1);
        @(posedge clk);
        contn <= 1'b1;
        wait_run(1'b0);
        repeat (4) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic run_program(input int p);
        logic [11:0] data;
        logic [11:0] exp_mem;
        int          count;
        int          i;
        data    = prog_table[p][f_data];
        exp_mem = prog_table[p][f_mem];
        count   = int'(prog_table[p][f_count]);
        if (prog_table[p][f_rand] != 12'd0)
        begin
            data    = lcg_next();
            exp_mem = data;        // the program copies the data word.
        end
        load_address(prog_table[p][f_start]);
        for (i = 0; i < count; i++)
            deposit_word(prog_table[p][f_code + i]);
        load_address(prog_table[p][f_daddr]);
        deposit_word(data);
        load_address(prog_table[p][f_start]);
        @(posedge clk);
        sr <= run_sr;              // read back by OSR.
        continue_run();
        check_value($sformatf("ac of program %0d", p), ac, prog_table[p][f_ac]);
        check_value($sformatf("link of program %0d", p), {11'd0, link}, prog_table[p][f_link]);
        check_value($sformatf("pc of program %0d", p), pc, prog_table[p][f_pc]);
        load_address(prog_table[p][f_chk]);
        examine_word();
        check_value($sformatf("mb of program %0d", p), mb, exp_mem);
        press_key(key_clear);
        check_value("ac after clear", ac, 12'o0000);
        check_value("link after clear", {11'd0, link}, 12'd0);
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial
    begin
        logic [11:0] words [4];
        logic [11:0] addr;
        int          i;
        int          p;

        sr           <= '0;
        addr_loadn   <= 1'b1;
        depn         <= 1'b1;
        examn        <= 1'b1;
        contn        <= 1'b1;
        clearn       <= 1'b1;
        haltn        <= 1'b1;
        single_stepn <= 1'b1;
        lcg_state    = 88;
        fill_table();

        wait_reset();
        @(negedge clk);
        check_value("run after reset", {11'd0, run}, 12'd0);

        addr = 12'o3000;
        load_address(addr);
        check_value("pc after load address", pc, addr);
        for (i = 0; i < 4; i++)
        begin
            words[i] = lcg_next();
            deposit_word(words[i]);
            addr = addr + 12'd1;
            check_value("pc after deposit", pc, addr);
        end
        addr = 12'o3000;
        load_address(addr);
        for (i = 0; i < 4; i++)
        begin
            examine_word();
            addr = addr + 12'd1;
            check_value("mb after examine", mb, words[i]);
            check_value("pc after examine", pc, addr);
        end

        for (p = 0; p < n_progs; p++)
            run_program(p);

        // one instruction of the group-1 program, CLA CLL CMA IAC.
        load_address(12'o1000);
        @(posedge clk);
        single_stepn <= 1'b0;
        continue_run();
        check_value("pc after single step", pc, 12'o1001);
        check_value("ac after single step", ac, 12'o0000);
        check_value("link after single step", {11'd0, link}, 12'd1);
        @(posedge clk);
        single_stepn <= 1'b1;
        repeat (4) @(posedge clk);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- pdp8_core.f
rtl/pdp8_pkg.sv
rtl/front_panel.sv
rtl/state_machine.sv
rtl/ma.sv
rtl/ac.sv
rtl/oper2.sv
rtl/pdp8_core.sv
testbench/tb_clock.sv
testbench/pdp8_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pdp8_core_tb -f pdp8_core.f -o pdp8_core_sim

status=0
./obj_dir/pdp8_core_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Finished with no errors" sim.log; then
    echo "simulation did not complete"
    exit 1
fi
echo "simulation passed"
